/* logic/bridge_ram_pkg.sv */
/* bridge to byte SRAM adapter
   shared command and response structs and memory sizing constants. */
package bridge_ram_pkg;

	// byte address bits kept by the SRAM, higher bits wrap.
	localparam int SRAM_ADDR_BITS = 12;
	localparam int SRAM_DEPTH = 2 ** SRAM_ADDR_BITS;

	// cycles busy stays up after the strobe cycle.
	localparam int SRAM_WAIT_CYCLES = 3;
	localparam int WAIT_CNT_BITS = $clog2(SRAM_WAIT_CYCLES + 1);

	// flops per clock crossing.
	localparam int SYNC_DEPTH = 3;

	// top address byte of the bridge's own register space.
	localparam logic [7:0] RESERVED_PAGE = 8'hF8;

	// command from the host bridge, held at level until ack.
	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [31:0] addr;
		logic [31:0] wr_data;
	} bridge_req_t;

	// response back toward the bridge.
	typedef struct packed {
		logic        ack;
		logic [31:0] rd_data;
	} bridge_rsp_t;

	// single byte access to the SRAM controller.
	typedef struct packed {
		logic                      rd;
		logic                      wr;
		logic [SRAM_ADDR_BITS-1:0] addr;
		logic [7:0]                data;
	} sram_cmd_t;

endpackage

/* logic/sync_stage.sv */
/* multi-flop synchronizer
   moves a level-held payload into the destination clock domain. */
`timescale 1ns/1ps

module sync_stage
	import bridge_ram_pkg::*;
#(
	parameter type sync_t = logic
) (
	input  logic  clk_sys,
	input  logic  reset_l,
	input  sync_t d,
	output sync_t q
);

	// stage 0 may go metastable, later stages settle it.
	sync_t stages [SYNC_DEPTH];

	always_ff @(posedge clk_sys or negedge reset_l) begin
		if (!reset_l) begin
			for (int i = 0; i < SYNC_DEPTH; i++) begin
				stages[i] <= '0;
			end
		end else begin
			stages[0] <= d;
			for (int i = 1; i < SYNC_DEPTH; i++) begin
				stages[i] <= stages[i-1];
			end
		end
	end

	assign q = stages[SYNC_DEPTH-1];

endmodule

/* logic/byte_access_sequencer.sv */
/* byte access sequencer
   splits one 32-bit bridge command into four SRAM byte accesses. */
`timescale 1ns/1ps

module byte_access_sequencer
	import bridge_ram_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset_l,
	input  logic        big_endian,
	input  bridge_req_t req,
	output bridge_rsp_t rsp,
	output sram_cmd_t   sram_cmd,
	input  logic [7:0]  word_q,
	input  logic        word_busy
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_CHECK,
		S_ISSUE,
		S_WAIT,
		S_DONE,
		S_ACK
	} seq_state_t;

	seq_state_t state;

	logic prev_rd;
	logic prev_wr;
	logic req_edge;
	logic is_read;
	logic endian_q;
	logic [1:0] byte_idx;
	logic [1:0] issue_idx;
	logic issue_now;

	logic [31:0] base_addr;
	logic [31:0] wr_word;

	logic strobe_rd;
	logic strobe_wr;
	logic [SRAM_ADDR_BITS-1:0] cmd_addr;
	logic [7:0] cmd_data;

	// lane 0 is bits 7:0 of the word.
	// in big endian order the base address byte lands in lane 3.
	function automatic logic [1:0] lane_of(input logic [1:0] idx, input logic be);
		logic [1:0] lane;
		lane = be ? (2'd3 - idx) : idx;
		return lane;
	endfunction

	assign req_edge = (req.rd & ~prev_rd) | (req.wr & ~prev_wr);

	// first byte goes out from S_ISSUE, the rest straight from S_WAIT.
	assign issue_now = !word_busy &&
		((state == S_ISSUE) || (state == S_WAIT && byte_idx != 2'd3));
	assign issue_idx = (state == S_WAIT) ? byte_idx + 2'd1 : byte_idx;

	always_ff @(posedge clk_sys or negedge reset_l) begin
		if (!reset_l) begin
			state     <= S_IDLE;
			prev_rd   <= 1'b0;
			prev_wr   <= 1'b0;
			is_read   <= 1'b0;
			endian_q  <= 1'b0;
			byte_idx  <= 2'd0;
			strobe_rd <= 1'b0;
			strobe_wr <= 1'b0;
			rsp       <= '0;
		end else begin
			prev_rd   <= req.rd;
			prev_wr   <= req.wr;
			strobe_rd <= 1'b0;
			strobe_wr <= 1'b0;

			if (issue_now) begin
				strobe_rd <= is_read;
				strobe_wr <= !is_read;
			end

			case (state)
				S_IDLE: begin
					if (req_edge) begin
						is_read     <= req.rd;
						endian_q    <= big_endian;
						byte_idx    <= 2'd0;
						// cleared early so it is stable well before ack.
						rsp.rd_data <= '0;
						state       <= S_CHECK;
					end
				end
				S_CHECK: begin
					// register space is answered here, memory untouched.
					if (base_addr[31:24] == RESERVED_PAGE) begin
						rsp.ack <= 1'b1;
						state   <= S_ACK;
					end else begin
						state <= S_ISSUE;
					end
				end
				S_ISSUE: begin
					if (issue_now) begin
						state <= S_WAIT;
					end
				end
				S_WAIT: begin
					// first cycle here is the strobe cycle, busy is up.
					if (!word_busy) begin
						if (is_read) begin
							rsp.rd_data[lane_of(byte_idx, endian_q)*8 +: 8] <= word_q;
						end
						if (byte_idx == 2'd3) begin
							state <= S_DONE;
						end else begin
							byte_idx <= byte_idx + 2'd1;
						end
					end
				end
				S_DONE: begin
					// rd_data settled last cycle, ack follows.
					rsp.ack <= 1'b1;
					state   <= S_ACK;
				end
				S_ACK: begin
					if (!req.rd && !req.wr) begin
						rsp.ack <= 1'b0;
						state   <= S_IDLE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// command payload, only sampled alongside a strobe.
	always_ff @(posedge clk_sys) begin
		if (state == S_IDLE && req_edge) begin
			base_addr <= req.addr;
			wr_word   <= req.wr_data;
		end
		if (issue_now) begin
			cmd_addr <= base_addr[SRAM_ADDR_BITS-1:0] + SRAM_ADDR_BITS'(issue_idx);
			cmd_data <= wr_word[lane_of(issue_idx, endian_q)*8 +: 8];
		end
	end

	assign sram_cmd.rd   = strobe_rd;
	assign sram_cmd.wr   = strobe_wr;
	assign sram_cmd.addr = cmd_addr;
	assign sram_cmd.data = cmd_data;

endmodule

/* logic/byte_sram_ctrl.sv */
/* byte-wide SRAM controller
   behavioral byte storage behind a fixed-latency busy handshake. */
`timescale 1ns/1ps

module byte_sram_ctrl
	import bridge_ram_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset_l,
	input  sram_cmd_t  sram_cmd,
	output logic [7:0] word_q,
	output logic       word_busy
);

	logic strobe;
	logic [WAIT_CNT_BITS-1:0] wait_cnt;

	// storage, one byte per address.
	logic [7:0] mem [SRAM_DEPTH];

	assign strobe = sram_cmd.rd | sram_cmd.wr;

	// wait counter.
	// loaded on a strobe and counts down to idle.
	always_ff @(posedge clk_sys or negedge reset_l) begin
		if (!reset_l) begin
			wait_cnt <= '0;
		end else if (strobe) begin
			wait_cnt <= WAIT_CNT_BITS'(SRAM_WAIT_CYCLES);
		end else if (wait_cnt != '0) begin
			wait_cnt <= wait_cnt - WAIT_CNT_BITS'(1);
		end
	end

	// the strobe cycle itself already counts as busy.
	assign word_busy = strobe | (wait_cnt != '0);

	// write port.
	always_ff @(posedge clk_sys) begin
		if (sram_cmd.wr) begin
			mem[sram_cmd.addr] <= sram_cmd.data;
		end
	end

	// read data is held until the next read strobe.
	always_ff @(posedge clk_sys) begin
		if (sram_cmd.rd) begin
			word_q <= mem[sram_cmd.addr];
		end
	end

endmodule

/* logic/bridge_ram_top.sv */
/* bridge to byte SRAM adapter top
   crosses bridge commands into clk_sys and sequences them onto the SRAM. */
`timescale 1ns/1ps

module bridge_ram_top
	import bridge_ram_pkg::*;
(
	input  logic        clk_sys,
	input  logic        clk_bridge,
	input  logic        reset_l,
	input  logic        big_endian,
	input  bridge_req_t bridge_req,
	output bridge_rsp_t bridge_rsp
);

	bridge_req_t req_sys;
	bridge_rsp_t rsp_sys;
	sram_cmd_t   sram_cmd;
	logic [7:0]  word_q;
	logic        word_busy;

	// bridge command into clk_sys.
	sync_stage #(
		.sync_t(bridge_req_t)
	) sync_req (
		.clk_sys (clk_sys),
		.reset_l (reset_l),
		.d       (bridge_req),
		.q       (req_sys)
	);

	// response back on the bridge clock.
	sync_stage #(
		.sync_t(bridge_rsp_t)
	) sync_rsp (
		.clk_sys (clk_bridge),
		.reset_l (reset_l),
		.d       (rsp_sys),
		.q       (bridge_rsp)
	);

	byte_access_sequencer u_sequencer (
		.clk_sys    (clk_sys),
		.reset_l    (reset_l),
		.big_endian (big_endian),
		.req        (req_sys),
		.rsp        (rsp_sys),
		.sram_cmd   (sram_cmd),
		.word_q     (word_q),
		.word_busy  (word_busy)
	);

	byte_sram_ctrl u_sram (
		.clk_sys   (clk_sys),
		.reset_l   (reset_l),
		.sram_cmd  (sram_cmd),
		.word_q    (word_q),
		.word_busy (word_busy)
	);

endmodule

/* verif/bridge_ram_tb.sv */
/* bridge to byte SRAM adapter testbench
   drives bridge commands on a slow clock and checks reads against a byte model. */
`timescale 1ns/1ps

module bridge_ram_tb
	import bridge_ram_pkg::*;
();

	logic        clk_sys;
	logic        clk_bridge;
	logic        reset_l;
	logic        big_endian;
	bridge_req_t bridge_req;
	bridge_rsp_t bridge_rsp;

	logic [7:0]  ref_mem [SRAM_DEPTH];
	logic        seen_req;
	logic        cur_read;
	logic [31:0] exp_data;
	logic        ack_prev;
	int          ack_rises;
	int          cmd_count;
	string       test_name;

	bridge_ram_top uut (
		.clk_sys    (clk_sys),
		.clk_bridge (clk_bridge),
		.reset_l    (reset_l),
		.big_endian (big_endian),
		.bridge_req (bridge_req),
		.bridge_rsp (bridge_rsp)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	initial begin
		clk_bridge = 1'b0;
		forever #6.5 clk_bridge = ~clk_bridge;
	end

	// response stays quiet until the first request.
	reset_quiet: assert property (@(posedge clk_bridge) disable iff (!reset_l)
		!seen_req |-> (bridge_rsp.ack == 1'b0 && bridge_rsp.rd_data == 32'h0))
	else begin
		$display("mismatch %s expected ack 0 data 00000000 actual ack %0b data %08h",
			test_name, $sampled(bridge_rsp.ack), $sampled(bridge_rsp.rd_data));
		$display("Test failed");
		$fatal(1);
	end

	read_data_ok: assert property (@(posedge clk_bridge) disable iff (!reset_l)
		($rose(bridge_rsp.ack) && cur_read) |-> (bridge_rsp.rd_data == exp_data))
	else begin
		$display("mismatch %s expected %08h actual %08h",
			test_name, $sampled(exp_data), $sampled(bridge_rsp.rd_data));
		$display("Test failed");
		$fatal(1);
	end

	// ack is a registered answer to the request held one bridge cycle before.
	ack_needs_req: assert property (@(posedge clk_bridge) disable iff (!reset_l)
		$rose(bridge_rsp.ack) |-> $past(bridge_req.rd || bridge_req.wr))
	else begin
		$display("%s: ack rose while no request was pending", test_name);
		$display("Test failed");
		$fatal(1);
	end

	// count ack rising edges seen by the bridge.
	always @(posedge clk_bridge or negedge reset_l) begin
		if (!reset_l) begin
			ack_prev  <= 1'b0;
			ack_rises <= 0;
		end else begin
			ack_prev <= bridge_rsp.ack;
			if (bridge_rsp.ack && !ack_prev) begin
				ack_rises <= ack_rises + 1;
			end
		end
	end

	// base address byte is the MSB in big endian, the LSB otherwise.
	function automatic logic [31:0] model_read(input logic [31:0] addr, input logic be);
		logic [31:0] word;
		logic [SRAM_ADDR_BITS-1:0] a;
		word = 32'h0;
		if (addr[31:24] != RESERVED_PAGE) begin
			for (int i = 0; i < 4; i++) begin
				a = addr[SRAM_ADDR_BITS-1:0] + SRAM_ADDR_BITS'(i);
				if (be) begin
					word[(3-i)*8 +: 8] = ref_mem[a];
				end else begin
					word[i*8 +: 8] = ref_mem[a];
				end
			end
		end
		return word;
	endfunction

	task automatic model_write(input logic [31:0] addr, input logic [31:0] data, input logic be);
		logic [SRAM_ADDR_BITS-1:0] a;
		if (addr[31:24] != RESERVED_PAGE) begin
			for (int i = 0; i < 4; i++) begin
				a = addr[SRAM_ADDR_BITS-1:0] + SRAM_ADDR_BITS'(i);
				ref_mem[a] = be ? data[(3-i)*8 +: 8] : data[i*8 +: 8];
			end
		end
	endtask

	// random upper bits, low bits inside the preloaded window around 0xFC0.
	function automatic logic [31:0] window_addr(input int unsigned off);
		logic [31:0] addr;
		addr = $urandom();
		addr[SRAM_ADDR_BITS-1:0] = SRAM_ADDR_BITS'(32'hFC0 + off);
		if (addr[31:24] == RESERVED_PAGE) begin
			addr[31:24] = 8'h00;
		end
		return addr;
	endfunction

	// bounded at 400 bridge cycles.
	task automatic wait_ack(input logic level);
		int waited;
		waited = 0;
		while (bridge_rsp.ack !== level) begin
			if (waited >= 400) begin
				$display("Test failed");
				$fatal(1, "%s: ack never %s", test_name, level ? "arrived" : "returned low");
			end else begin
				@(negedge clk_bridge);
				waited++;
			end
		end
	endtask

	task automatic do_cmd(input logic is_wr, input logic [31:0] addr, input logic [31:0] data);
		@(negedge clk_bridge);
		cur_read = !is_wr;
		exp_data = is_wr ? 32'h0 : model_read(addr, big_endian);
		if (is_wr) begin
			model_write(addr, data, big_endian);
		end
		bridge_req.addr    = addr;
		bridge_req.wr_data = data;
		bridge_req.rd      = !is_wr;
		bridge_req.wr      = is_wr;
		seen_req = 1'b1;
		cmd_count++;
		wait_ack(1'b1);
		bridge_req.rd = 1'b0;
		bridge_req.wr = 1'b0;
		wait_ack(1'b0);
		assert (ack_rises == cmd_count) else begin
			$display("mismatch %s ack count expected %0d actual %0d",
				test_name, cmd_count, ack_rises);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// 128 bytes from 0xFC0, wrapping through 0x000.
	task automatic preload_window();
		test_name = "preload";
		for (int k = 0; k < 32; k++) begin
			do_cmd(1'b1, 32'h0000_0FC0 + 32'(k * 4), $urandom());
		end
	endtask

	task automatic endian_check(input logic be, input string name);
		logic [31:0] addr;
		logic [31:0] word;
		test_name = name;
		@(negedge clk_bridge);
		big_endian = be;
		addr = window_addr($urandom_range(0, 123));
		word = $urandom();
		do_cmd(1'b1, addr, word);
		do_cmd(1'b0, addr, 32'h0);
		do_cmd(1'b0, addr + 32'd1, 32'h0);
	endtask

	task automatic reserved_check();
		test_name = "reserved_page";
		do_cmd(1'b1, {RESERVED_PAGE, 24'h000010}, 32'hDEAD_BEEF);
		do_cmd(1'b0, 32'h0000_0010, 32'h0);
		do_cmd(1'b0, {RESERVED_PAGE, 24'h000010}, 32'h0);
	endtask

	task automatic random_mix(input int count);
		logic [31:0] addr;
		test_name = "random_mix";
		for (int n = 0; n < count; n++) begin
			@(negedge clk_bridge);
			big_endian = $urandom_range(0, 1);
			addr = window_addr($urandom_range(0, 124));
			if ($urandom_range(0, 7) == 0) begin
				addr[31:24] = RESERVED_PAGE;
			end
			do_cmd($urandom_range(0, 1), addr, $urandom());
		end
	endtask

	initial begin
		void'($urandom(47152));
		reset_l    = 1'b0;
		big_endian = 1'b0;
		bridge_req = '0;
		seen_req   = 1'b0;
		cur_read   = 1'b0;
		exp_data   = 32'h0;
		cmd_count  = 0;
		test_name  = "reset";
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		reset_l = 1'b1;
		// idle stretch so the quiet response is observed.
		repeat (20) @(negedge clk_bridge);
		preload_window();
		endian_check(1'b1, "big_endian");
		endian_check(1'b0, "little_endian");
		reserved_check();
		random_mix(40);
		$display("Test passed");
		$finish;
	end

endmodule

/* sim.f */
logic/bridge_ram_pkg.sv
logic/sync_stage.sv
logic/byte_access_sequencer.sv
logic/byte_sram_ctrl.sv
logic/bridge_ram_top.sv
verif/bridge_ram_tb.sv

/* Bender.yml */
package:
  name: bridge_ram

sources:
  - logic/bridge_ram_pkg.sv
  - logic/sync_stage.sv
  - logic/byte_access_sequencer.sv
  - logic/byte_sram_ctrl.sv
  - logic/bridge_ram_top.sv
  - target: test
    files:
      - verif/bridge_ram_tb.sv
